// ==== baudTickGen.sv ====
// free-running oversampling tick; one-clock sTick every baudDivisor clocks, never stopped after reset
`default_nettype none
`timescale 1ns/1ps

module baudTickGen import uartTxPkg::*;
(
	input logic clk,
	input logic reset,
	output logic sTick		// one-clock pulse
);

	logic [baudCntrWidth-1:0] divCnt;	// modulo baudDivisor
	logic wrap;

	assign wrap = (divCnt == baudCntrWidth'(baudDivisor - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			if (wrap)
				divCnt <= '0;	// restart the period
			else
				divCnt <= divCnt + 1'b1;
			sTick <= wrap;	// registered, so glitch free
		end
	end

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module uartTxTb -f uartTx.f --Mdir simBuild -o uartTxSim
./simBuild/uartTxSim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log
then
	exit 1
fi
exit 0

// ==== tbClockGen.sv ====
// testbench clock and reset only; 20 ns period, reset held high for the first 4 cycles
`default_nettype none
`timescale 1ns/1ps

module tbClockGen
(
	output logic clk,
	output logic reset
);

	localparam time halfPeriod = 10;	// 20 ns clock

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		#(8 * halfPeriod);	// four full cycles
		reset = 1'b0;	// released on a falling edge, away from the sampling edge
	end

	always #(halfPeriod) clk = ~clk;

endmodule

`default_nettype wire

// ==== txFifo.sv ====
// writes while full are dropped silently; pop must only be pulsed while not empty, rdData is the head shown combinationally
`default_nettype none
`timescale 1ns/1ps

module txFifo import uartTxPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [dataBits-1:0] wrData,	// byte from the host
	input logic wrEn,		// one-cycle write strobe
	input logic pop,		// one-cycle read pulse from serializer
	output logic [dataBits-1:0] rdData,	// head entry
	output txFifoStatus status
);

	logic [dataBits-1:0] mem [fifoDepth];	// byte storage, no reset
	logic [fifoAddrWidth-1:0] wrPtr;
	logic [fifoAddrWidth-1:0] rdPtr;
	logic [fifoCntrWidth-1:0] countReg;	// occupancy
	logic full;
	logic empty;
	logic doWrite;
	logic doPop;

	// flags straight off the registered count
	assign full = (countReg == fifoCntrWidth'(fifoDepth));
	assign empty = (countReg == '0);

	assign doWrite = wrEn & ~full;	// full blocks the write
	assign doPop = pop & ~empty;		// guard against a stray pop

	////////////////////
	// storage
	////////////////////
	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];	// head visible without a read cycle

	////////////////////
	// pointers and count
	////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			countReg <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// write and pop together leave the count alone
			case ({doWrite, doPop})
				2'b10: countReg <= countReg + fifoCntrWidth'(1);
				2'b01: countReg <= countReg - fifoCntrWidth'(1);
				default: countReg <= countReg;
			endcase
		end
	end

	// status word out to serializer and host
	assign status.count = countReg;
	assign status.full = full;
	assign status.empty = empty;

endmodule

`default_nettype wire

// ==== uartTrans.sv ====
// 8N1 serializer; start bit ends on the 16th tick so its length jitters by up to baudDivisor clocks
`default_nettype none
`timescale 1ns/1ps

module uartTrans import uartTxPkg::*;
(
	input logic clk,
	input logic reset,
	input logic sTick,		// oversampling tick
	input logic txStart,		// level, fifo holds data
	input logic [dataBits-1:0] din,	// fifo head
	output logic txDoneTick,	// pop pulse back to fifo
	output logic tx,		// serial line, idles high
	output logic busy
);

	logic [1:0] stateReg;
	logic [1:0] stateNext;
	logic [tickCntrWidth-1:0] sReg;	// ticks within a bit
	logic [tickCntrWidth-1:0] sNext;
	logic [bitCntrWidth-1:0] nReg;	// data bit index
	logic [bitCntrWidth-1:0] nNext;
	logic [dataBits-1:0] bReg;		// shift register, lsb goes out first
	logic [dataBits-1:0] bNext;
	logic txReg;
	logic txNext;
	logic lastBitTick;		// 16th tick of a start/data bit
	logic lastStopTick;

	assign lastBitTick = sTick & (sReg == tickCntrWidth'(ticksPerBit - 1));
	assign lastStopTick = sTick & (sReg == tickCntrWidth'(sbTick - 1));

	////////////////////
	// state registers
	////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////
	// next state
	////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;	// tx only changes on bit boundaries
		txDoneTick = 1'b0;

		case (stateReg)
			stIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// pop and capture in the same cycle
					bNext = din;
					txNext = 1'b0;	// start bit on the next clock
					sNext = '0;
					stateNext = stStart;
				end
			end

			stStart:
			begin
				if (lastBitTick)
				begin
					sNext = '0;
					nNext = '0;
					txNext = bReg[0];	// first data bit
					stateNext = stData;
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			stData:
			begin
				if (lastBitTick)
				begin
					sNext = '0;
					bNext = bReg >> 1;	// drop the bit just sent
					if (nReg == bitCntrWidth'(dataBits - 1))
					begin
						txNext = 1'b1;	// stop bit
						stateNext = stStop;
					end
					else
					begin
						nNext = nReg + 1'b1;
						txNext = bReg[1];	// next bit up
					end
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			stStop:
			begin
				if (lastStopTick)
				begin
					sNext = '0;
					stateNext = stIdle;	// next pop can follow right away
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			default: stateNext = stIdle;
		endcase
	end

	assign tx = txReg;
	assign busy = (stateReg != stIdle);

endmodule

`default_nettype wire

// ==== uartTx.f ====
uartTxPkg.sv
txFifo.sv
baudTickGen.sv
uartTrans.sv
uartTxTop.sv
tbClockGen.sv
uartTxMonitor.sv
uartTxTb.sv

// ==== uartTxMonitor.sv ====
// decodes tx frames at bit centres; start bit jitter must stay under half a bit, expected list holds 128 frames
`default_nettype none
`timescale 1ns/1ps

module uartTxMonitor import uartTxPkg::*;
(
	input logic clk,
	input logic reset,
	input logic tx,
	input txFifoStatus txStatus,
	input logic [dataBits+1:0] expFrames [0:127],	// expected line patterns, in write order
	input int expWrIdx,		// entries filled by the stimulus
	output int frameCount,		// frames decoded so far, also the read index
	output int frameErrors,
	output int countErrors
);

	localparam int bitClocks = ticksPerBit * baudDivisor;
	logic prevTx;

	////////////////////
	// frame decoder
	////////////////////
	initial
	begin : frameWatch
		logic [dataBits+1:0] seen;	// bit 0 = start bit
		logic [dataBits+1:0] want;
		int i;
		int k;
		frameCount = 0;
		frameErrors = 0;
		prevTx = 1'b1;
		forever
		begin
			@(negedge clk);
			if (!reset && prevTx && !tx)
			begin
				for (k = 0; k < bitClocks / 2; k++)	// to the middle of the start bit
					@(negedge clk);
				for (i = 0; i < dataBits + 2; i++)
				begin
					seen[i] = tx;
					if (i < dataBits + 1)
						for (k = 0; k < bitClocks; k++)
							@(negedge clk);
				end
				if (frameCount >= expWrIdx)
				begin
					$display("unexpected frame at time %0t, no byte was waiting (line %b)",
						$time, seen);
					frameErrors++;
				end
				else
				begin
					want = expFrames[frameCount];
					if (seen !== want)
					begin
						$display("mismatch at time %0t: frame %0d expected %b, observed %b",
							$time, frameCount, want, seen);
						frameErrors++;
					end
					frameCount++;	// head consumed
				end
			end
			prevTx = tx;
		end
	end

	// occupancy must never pass the fifo depth
	initial
	begin
		countErrors = 0;
		forever
		begin
			@(negedge clk);
			if (!reset && int'(txStatus.count) > fifoDepth)
			begin
				$display("mismatch at time %0t: fifo count %0d above depth %0d",
					$time, txStatus.count, fifoDepth);
				countErrors++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== uartTxPkg.sv ====
// uart tx sizes and types; fifoDepth must equal 2**fifoAddrWidth, sbTick and ticksPerBit <= 16, baudDivisor >= 2
`default_nettype none

package uartTxPkg;

	////////////////////
	// frame format
	////////////////////
	localparam int dataBits = 8;		// data bits per frame, lsb first
	localparam int sbTick = 16;		// ticks in the stop bit (16 = one stop bit)
	localparam int ticksPerBit = 16;	// oversampling ticks per start/data bit

	// counter widths inside the serializer
	localparam int tickCntrWidth = 4;	// holds 0..15 ticks
	localparam int bitCntrWidth = $clog2(dataBits);	// data bit index

	////////////////////
	// baud generation
	////////////////////
	localparam int baudDivisor = 4;	// clocks per sTick, kept small for sim
	localparam int baudCntrWidth = $clog2(baudDivisor);

	////////////////////
	// fifo
	////////////////////
	localparam int fifoDepth = 16;
	localparam int fifoAddrWidth = 4;	// pointers wrap naturally at fifoDepth
	localparam int fifoCntrWidth = 5;	// count 0..16 needs the extra bit

	// serializer states
	localparam logic [1:0] stIdle = 2'b00;
	localparam logic [1:0] stStart = 2'b01;
	localparam logic [1:0] stData = 2'b10;
	localparam logic [1:0] stStop = 2'b11;

	// fifo status word, also seen by the host as txStatus
	typedef struct packed {
		logic [fifoCntrWidth-1:0] count;	// entries held
		logic full;		// count == fifoDepth
		logic empty;		// count == 0
	} txFifoStatus;

endpackage

`default_nettype wire

// ==== uartTxTb.sv ====
// uart tx testbench top; inputs change 1 ns after the rising edge, expected list limited to 128 bytes
`default_nettype none
`timescale 1ns/1ps

module uartTxTb import uartTxPkg::*;
();

	localparam int frameLen = dataBits + 2;	// start + data + stop
	localparam int expDepth = 128;
	localparam int bitClocks = ticksPerBit * baudDivisor;

	logic clk;
	logic reset;
	logic [dataBits-1:0] wrData;
	logic wrEn;
	logic tx;
	txFifoStatus txStatus;
	logic txBusy;
	logic [frameLen-1:0] expFrames [0:expDepth-1];	// expected queue read by the monitor
	int expWrIdx;
	int frameCount;
	int frameErrors;
	int countErrors;
	int tbErrors;
	int timeouts;
	int passCount;
	bit timedOut;
	bit fullSeen;
	logic [31:0] rngState;

	tbClockGen clkGen (.clk(clk), .reset(reset));

	uartTxTop dut (
		.clk(clk),
		.reset(reset),
		.wrData(wrData),
		.wrEn(wrEn),
		.tx(tx),
		.txStatus(txStatus),
		.txBusy(txBusy)
	);

	uartTxMonitor mon (
		.clk(clk),
		.reset(reset),
		.tx(tx),
		.txStatus(txStatus),
		.expFrames(expFrames),
		.expWrIdx(expWrIdx),
		.frameCount(frameCount),
		.frameErrors(frameErrors),
		.countErrors(countErrors)
	);

	////////////////////
	// reference model
	////////////////////
	// line pattern in send order with bit 0 going out first
	function automatic logic [frameLen-1:0] frameBits(input logic [dataBits-1:0] b);
		return {1'b1, b, 1'b0};
	endfunction

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int totalErrors();
		return tbErrors + frameErrors + countErrors + timeouts;
	endfunction

	// one clock of stimulus; a byte counts as sent only if full is low now
	task automatic driveCycle(input logic en, input logic [dataBits-1:0] b);
		wrEn = en;
		wrData = b;
		if (txStatus.full)
			fullSeen = 1'b1;
		else if (en && expWrIdx < expDepth)
		begin
			expFrames[expWrIdx] = frameBits(b);
			expWrIdx++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic checkEq(input string what, input int got, input int want);
		if (got != want)
		begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, want);
			tbErrors++;
		end
	endtask

	// waits until the serializer is idle with the fifo empty; tracks the longest busy-low stretch
	task automatic waitDrain(input string what, input int limit, output int longestIdle);
		int n;
		int idleRun;
		wrEn = 1'b0;
		longestIdle = 0;
		idleRun = 0;
		n = 0;
		while ((txBusy || !txStatus.empty) && n < limit)
		begin
			if (!txBusy && frameCount < expWrIdx)
				idleRun++;
			else
				idleRun = 0;
			if (idleRun > longestIdle)
				longestIdle = idleRun;
			@(posedge clk);
			#1;
			n++;
		end
		if (txBusy || !txStatus.empty)
		begin
			$display("timeout: %s did not finish within %0d clocks", what, limit);
			timeouts++;
			timedOut = 1'b1;
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		int errs;
		errs = totalErrors() - errsBefore;
		if (errs == 0)
		begin
			passCount++;
			$display("%s: pass", name);
		end
		else
			$display("%s: FAIL, %0d errors", name, errs);
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial
	begin : sequencer
		int errs0;
		int idle;
		int startFrames;
		int startIdx;
		int gap;
		int i;
		wrEn = 1'b0;
		wrData = '0;
		expWrIdx = 0;
		tbErrors = 0;
		timeouts = 0;
		passCount = 0;
		timedOut = 1'b0;
		fullSeen = 1'b0;
		rngState = 32'hb7884e4f;
		for (i = 0; i < expDepth; i++)
			expFrames[i] = '0;
		i = 0;
		// wait for reset release
		do
		begin
			@(posedge clk);
			#1;
			i++;
		end
		while (reset && i < 20);
		if (reset)
		begin
			$display("timeout: reset was never released");
			timeouts++;
			timedOut = 1'b1;
		end

		// test 1 quiet line after reset
		errs0 = totalErrors();
		for (i = 0; i < 200 && !timedOut; i++)
		begin
			checkEq("tx", int'(tx), 1);
			checkEq("txBusy", int'(txBusy), 0);
			checkEq("fifo count", int'(txStatus.count), 0);
			checkEq("fifo empty", int'(txStatus.empty), 1);
			checkEq("fifo full", int'(txStatus.full), 0);
			driveCycle(1'b0, '0);
		end
		reportTest("test 1 idle after reset", errs0);

		// test 2 one byte gives one frame
		if (!timedOut)
		begin
			errs0 = totalErrors();
			startFrames = frameCount;
			driveCycle(1'b1, 8'ha5);
			waitDrain("single byte frame", 2000, idle);
			checkEq("frames sent", frameCount - startFrames, 1);
			reportTest("test 2 single byte", errs0);
		end

		// test 3 burst of sixteen sent back to back
		if (!timedOut)
		begin
			errs0 = totalErrors();
			startFrames = frameCount;
			for (i = 0; i < 16; i++)
			begin
				rngState = lcgNext(rngState);
				driveCycle(1'b1, rngState[23:16]);
			end
			waitDrain("sixteen byte burst", 20000, idle);
			checkEq("frames sent", frameCount - startFrames, 16);
			if (idle > bitClocks)
			begin
				$display("mismatch at time %0t: idle gap of %0d clocks between frames",
					$time, idle);
				tbErrors++;
			end
			reportTest("test 3 burst of sixteen", errs0);
		end

		// test 4 overflow loses writes while full
		if (!timedOut)
		begin
			errs0 = totalErrors();
			startFrames = frameCount;
			startIdx = expWrIdx;
			fullSeen = 1'b0;
			for (i = 0; i < 20; i++)
			begin
				rngState = lcgNext(rngState);
				driveCycle(1'b1, rngState[23:16]);
			end
			waitDrain("overflow burst", 30000, idle);
			checkEq("frames sent", frameCount - startFrames, expWrIdx - startIdx);
			if (!fullSeen)
			begin
				$display("fifo full flag was never seen during the overflow burst");
				tbErrors++;
			end
			reportTest("test 4 overflow", errs0);
		end

		// test 5 random bytes with random gaps
		if (!timedOut)
		begin
			errs0 = totalErrors();
			for (i = 0; i < 40; i++)
			begin
				rngState = lcgNext(rngState);
				driveCycle(1'b1, rngState[23:16]);
				rngState = lcgNext(rngState);
				gap = int'((rngState >> 8) % 32'd301);	// 0..300 clocks
				repeat (gap)
					driveCycle(1'b0, '0);
			end
			waitDrain("random traffic", 40000, idle);
			checkEq("frames left in queue", expWrIdx - frameCount, 0);
			reportTest("test 5 random traffic", errs0);
		end

		$display("tests passed %0d, errors %0d", passCount, totalErrors());
		if (totalErrors() == 0 && !timedOut)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uartTxTop.sv ====
// uart transmit top; no back-pressure beyond status.full, bytes written while full are lost
`default_nettype none
`timescale 1ns/1ps

module uartTxTop import uartTxPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [dataBits-1:0] wrData,	// byte to send
	input logic wrEn,		// one-cycle strobe
	output logic tx,		// serial out
	output txFifoStatus txStatus,	// fifo count/full/empty
	output logic txBusy		// serializer not idle
);

	logic [dataBits-1:0] rdData;	// fifo head to serializer
	logic txDoneTick;		// pop pulse
	logic sTick;
	logic txStart;

	assign txStart = ~txStatus.empty;	// send whenever data waits

	////////////////////
	// input side
	////////////////////
	txFifo fifo (
		.clk(clk),
		.reset(reset),
		.wrData(wrData),
		.wrEn(wrEn),
		.pop(txDoneTick),
		.rdData(rdData),
		.status(txStatus)
	);

	// 16x oversampling tick
	baudTickGen tickGen (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	////////////////////
	// output side
	////////////////////
	uartTrans trans (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txStart(txStart),
		.din(rdData),
		.txDoneTick(txDoneTick),
		.tx(tx),
		.busy(txBusy)
	);

endmodule

`default_nettype wire
